// ==== src/flow_pkg.sv ====
package flow_pkg;

   // ------------------------------
   // table geometry
   // ------------------------------
   localparam int match_w     = 128;
   localparam int action_w    = 64;
   localparam int index_w     = 10;
   localparam int table_depth = 1024;

   // key rotation before the second hash fold
   localparam int hash_rot    = 5;

   // number of index-wide slices in one key, last one zero padded
   localparam int hash_slices = (match_w + index_w - 1) / index_w;

   // ------------------------------
   // flow entry format
   // ------------------------------
   typedef logic [match_w-1:0]  match_t;

   // all zero action means drop
   typedef logic [action_w-1:0] action_t;

   typedef logic [index_w-1:0]  index_t;

   // one table word, match in the upper bits
   typedef struct packed {
      match_t  match;
      action_t action;
   } entry_t;

endpackage

// ==== src/port_pkg.sv ====
package port_pkg;

   // ------------------------------
   // requesters
   // ------------------------------
   localparam int num_ports = 4;
   localparam int num_req   = num_ports + 1;

   // host sits just above the lookup ports
   localparam int host_id   = num_ports;

   localparam int cnt_w     = 32;

   typedef logic [2:0]       req_id_t;
   typedef logic [cnt_w-1:0] count_t;

   // ------------------------------
   // pipeline bookkeeping
   // ------------------------------
   // one request in flight
   typedef struct packed {
      logic             valid;
      req_id_t          id;
      logic             write;
      flow_pkg::index_t addr;
      flow_pkg::match_t key;
   } pipe_item_t;

   // hash stage result, idx_0 already holds the host address for host items
   typedef struct packed {
      pipe_item_t       item;
      flow_pkg::index_t idx_0;
      flow_pkg::index_t idx_1;
   } probe_t;

endpackage

// ==== src/lookup_arbiter.sv ====
`timescale 1ns/1ps

module lookup_arbiter (
   input  logic                           asclk,
   input  logic                           aresetn,
   input  logic [port_pkg::num_ports-1:0] port_req,
   input  flow_pkg::match_t               port_match [port_pkg::num_ports],
   input  logic                           host_req,
   input  logic                           host_wr,
   input  flow_pkg::index_t               host_addr,
   input  flow_pkg::match_t               host_match_in,
   output logic [port_pkg::num_ports-1:0] port_ack,
   output logic                           host_ack,
   output port_pkg::pipe_item_t           item
);

   logic [port_pkg::num_req-1:0] req_all;
   logic [port_pkg::num_req-1:0] ack_q;
   port_pkg::req_id_t            ptr;
   port_pkg::req_id_t            grant_id;
   logic                         grant_found;
   flow_pkg::match_t             grant_key;

   assign req_all  = {host_req, port_req};
   assign port_ack = ack_q[port_pkg::num_ports-1:0];
   assign host_ack = ack_q[port_pkg::host_id];

   // ------------------------------
   // round robin search
   // ------------------------------
   // first requester at or above the pointer that was not granted last cycle
   always_comb begin
      int cand;
      grant_found = 1'b0;
      grant_id    = '0;
      for (int k = 0; k < port_pkg::num_req; k++) begin
         cand = (int'(ptr) + k) % port_pkg::num_req;
         if (!grant_found && req_all[cand] && !ack_q[cand]) begin
            grant_found = 1'b1;
            grant_id    = port_pkg::req_id_t'(cand);
         end
      end
   end

   // winner's key, host key unless a port won
   always_comb begin
      grant_key = host_match_in;
      for (int p = 0; p < port_pkg::num_ports; p++) begin
         if (grant_id == port_pkg::req_id_t'(p)) begin
            grant_key = port_match[p];
         end
      end
   end

   // pointer walks every cycle even when idle
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         ptr <= '0;
      end else if (ptr == port_pkg::req_id_t'(port_pkg::num_req - 1)) begin
         ptr <= '0;
      end else begin
         ptr <= ptr + 1'b1;
      end
   end

   // ------------------------------
   // ack and item capture
   // ------------------------------
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         ack_q      <= '0;
         item.valid <= 1'b0;
      end else begin
         ack_q           <= '0;
         ack_q[grant_id] <= grant_found;
         item.valid      <= grant_found;
         item.id         <= grant_id;
         item.write      <= grant_found && host_wr &&
                            (grant_id == port_pkg::req_id_t'(port_pkg::host_id));
         item.addr       <= host_addr;
         item.key        <= grant_key;
      end
   end

   // a lookup port holds its request and key until acked
   for (genvar k = 0; k < port_pkg::num_ports; k++) begin : g_hold
      a_req_hold: assert property (@(posedge asclk) disable iff (!aresetn)
         port_req[k] && !ack_q[k] |=> port_req[k] && $stable(port_match[k]));
   end

endmodule

// ==== src/flow_hash.sv ====
`timescale 1ns/1ps

module flow_hash (
   input  logic                 asclk,
   input  logic                 aresetn,
   input  port_pkg::pipe_item_t item,
   output port_pkg::probe_t     probe
);

   flow_pkg::match_t key_rot;
   flow_pkg::index_t hash_0;
   flow_pkg::index_t hash_1;
   logic             is_host;

   // xor of all index-wide slices of the key
   function automatic flow_pkg::index_t fold(input flow_pkg::match_t key);
      logic [flow_pkg::hash_slices*flow_pkg::index_w-1:0] padded;
      flow_pkg::index_t                                    acc;
      padded = {{(flow_pkg::hash_slices*flow_pkg::index_w - flow_pkg::match_w){1'b0}}, key};
      acc    = '0;
      for (int s = 0; s < flow_pkg::hash_slices; s++) begin
         acc = acc ^ padded[s*flow_pkg::index_w +: flow_pkg::index_w];
      end
      return acc;
   endfunction

   // rotate left before the second fold
   assign key_rot = {item.key[flow_pkg::match_w-flow_pkg::hash_rot-1:0],
                     item.key[flow_pkg::match_w-1 -: flow_pkg::hash_rot]};

   assign hash_0  = fold(item.key);
   assign hash_1  = fold(key_rot);
   assign is_host = (item.id == port_pkg::req_id_t'(port_pkg::host_id));

   // ------------------------------
   // register probe
   // ------------------------------
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         probe.item.valid <= 1'b0;
      end else begin
         probe.item  <= item;
         probe.idx_1 <= hash_1;
         // host goes straight to its address
         if (is_host) begin
            probe.idx_0 <= item.addr;
         end else begin
            probe.idx_0 <= hash_0;
         end
      end
   end

endmodule

// ==== src/exact_table.sv ====
`timescale 1ns/1ps

module exact_table (
   input  logic                 asclk,
   input  logic                 aresetn,
   input  port_pkg::probe_t     probe,
   input  flow_pkg::entry_t     host_entry,
   output port_pkg::pipe_item_t item_q,
   output flow_pkg::entry_t     entry_0,
   output flow_pkg::entry_t     entry_1
);

   flow_pkg::entry_t mem [flow_pkg::table_depth];
   logic             do_write;

   assign do_write = probe.item.valid && probe.item.write;

   // ------------------------------
   // port 0, shared with host
   // ------------------------------
   always_ff @(posedge asclk) begin
      if (do_write) begin
         mem[probe.idx_0] <= host_entry;
      end
   end

   // write-first so host readback shows the new entry
   always_ff @(posedge asclk) begin
      if (do_write) begin
         entry_0 <= host_entry;
      end else begin
         entry_0 <= mem[probe.idx_0];
      end
   end

   // ------------------------------
   // port 1, read only
   // ------------------------------
   always_ff @(posedge asclk) begin
      entry_1 <= mem[probe.idx_1];
   end

   // item follows the read data
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         item_q.valid <= 1'b0;
      end else begin
         item_q <= probe.item;
      end
   end

   // only the host may write the table
   a_write_host: assert property (@(posedge asclk) disable iff (!aresetn)
      do_write |-> probe.item.id == port_pkg::req_id_t'(port_pkg::host_id));

endmodule

// ==== src/action_select.sv ====
`timescale 1ns/1ps

module action_select (
   input  logic                           asclk,
   input  logic                           aresetn,
   input  port_pkg::pipe_item_t           item_q,
   input  flow_pkg::entry_t               entry_0,
   input  flow_pkg::entry_t               entry_1,
   output logic [port_pkg::num_ports-1:0] port_done,
   output logic                           host_done,
   output flow_pkg::action_t              action_out,
   output flow_pkg::match_t               host_match_out,
   output flow_pkg::action_t              host_action_out,
   output port_pkg::count_t               exact_hit,
   output port_pkg::count_t               exact_miss,
   output port_pkg::count_t               drop_count [port_pkg::num_ports]
);

   logic              is_host;
   logic              lookup;
   logic              hit_0;
   logic              hit_1;
   flow_pkg::action_t sel_action;

   assign is_host = (item_q.id == port_pkg::req_id_t'(port_pkg::host_id));
   assign lookup  = item_q.valid && !is_host;

   // ------------------------------
   // compare both probes
   // ------------------------------
   assign hit_0 = (entry_0.match == item_q.key);
   assign hit_1 = (entry_1.match == item_q.key);

   // probe 0 wins and a miss gives drop
   always_comb begin
      if (hit_0) begin
         sel_action = entry_0.action;
      end else if (hit_1) begin
         sel_action = entry_1.action;
      end else begin
         sel_action = '0;
      end
   end

   // done pulses and lookup result
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         port_done  <= '0;
         host_done  <= 1'b0;
         action_out <= '0;
      end else begin
         for (int p = 0; p < port_pkg::num_ports; p++) begin
            port_done[p] <= lookup && (item_q.id == port_pkg::req_id_t'(p));
         end
         host_done <= item_q.valid && is_host;
         if (lookup) begin
            action_out <= sel_action;
         end
      end
   end

   // host readback comes from probe 0
   always_ff @(posedge asclk) begin
      if (item_q.valid && is_host) begin
         host_match_out  <= entry_0.match;
         host_action_out <= entry_0.action;
      end
   end

   // ------------------------------
   // counters
   // ------------------------------
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         exact_hit  <= '0;
         exact_miss <= '0;
         for (int p = 0; p < port_pkg::num_ports; p++) begin
            drop_count[p] <= '0;
         end
      end else if (lookup) begin
         if (hit_0 || hit_1) begin
            exact_hit <= exact_hit + 1'b1;
         end else begin
            exact_miss <= exact_miss + 1'b1;
            // a miss is a drop on the requesting port
            for (int p = 0; p < port_pkg::num_ports; p++) begin
               if (item_q.id == port_pkg::req_id_t'(p)) begin
                  drop_count[p] <= drop_count[p] + 1'b1;
               end
            end
         end
      end
   end

   // every valid item ends in exactly one done
   a_done_onehot: assert property (@(posedge asclk) disable iff (!aresetn)
      item_q.valid |=> $onehot({host_done, port_done}));

endmodule

// ==== src/flow_tbl_ctrl.sv ====
`timescale 1ns/1ps

module flow_tbl_ctrl (
   input  logic                           asclk,
   input  logic                           aresetn,

   // lookup ports
   input  logic [port_pkg::num_ports-1:0] port_req,
   input  flow_pkg::match_t               port_match [port_pkg::num_ports],
   output logic [port_pkg::num_ports-1:0] port_ack,
   output logic [port_pkg::num_ports-1:0] port_done,
   output flow_pkg::action_t              action_out,

   // host access
   input  logic                           host_req,
   input  logic                           host_wr,
   input  flow_pkg::index_t               host_addr,
   input  flow_pkg::match_t               host_match_in,
   input  flow_pkg::action_t              host_action_in,
   output logic                           host_ack,
   output logic                           host_done,
   output flow_pkg::match_t               host_match_out,
   output flow_pkg::action_t              host_action_out,

   // statistics
   output port_pkg::count_t               exact_hit,
   output port_pkg::count_t               exact_miss,
   output port_pkg::count_t               drop_count [port_pkg::num_ports]
);

   port_pkg::pipe_item_t item;
   port_pkg::probe_t     probe;
   port_pkg::pipe_item_t item_q;
   flow_pkg::entry_t     host_entry;
   flow_pkg::entry_t     entry_0;
   flow_pkg::entry_t     entry_1;

   assign host_entry = {host_match_in, host_action_in};

   // ------------------------------
   // pipeline
   // ------------------------------
   lookup_arbiter u_arbiter (
      .asclk         (asclk),
      .aresetn       (aresetn),
      .port_req      (port_req),
      .port_match    (port_match),
      .host_req      (host_req),
      .host_wr       (host_wr),
      .host_addr     (host_addr),
      .host_match_in (host_match_in),
      .port_ack      (port_ack),
      .host_ack      (host_ack),
      .item          (item)
   );

   flow_hash u_hash (
      .asclk   (asclk),
      .aresetn (aresetn),
      .item    (item),
      .probe   (probe)
   );

   exact_table u_table (
      .asclk      (asclk),
      .aresetn    (aresetn),
      .probe      (probe),
      .host_entry (host_entry),
      .item_q     (item_q),
      .entry_0    (entry_0),
      .entry_1    (entry_1)
   );

   action_select u_select (
      .asclk           (asclk),
      .aresetn         (aresetn),
      .item_q          (item_q),
      .entry_0         (entry_0),
      .entry_1         (entry_1),
      .port_done       (port_done),
      .host_done       (host_done),
      .action_out      (action_out),
      .host_match_out  (host_match_out),
      .host_action_out (host_action_out),
      .exact_hit       (exact_hit),
      .exact_miss      (exact_miss),
      .drop_count      (drop_count)
   );

endmodule

// ==== sim/tb_tasks.svh ====
// ------------------------------
// reference model state
// ------------------------------
flow_pkg::entry_t  shadow [flow_pkg::table_depth];
bit                written [flow_pkg::table_depth];
flow_pkg::index_t  wr_addrs [$];
port_pkg::count_t  exp_hit = '0;
port_pkg::count_t  exp_miss = '0;
port_pkg::count_t  exp_drop [port_pkg::num_ports] = '{default: '0};

// results of a stream, in grant order
flow_pkg::action_t stream_act [$];
int                stream_cyc [$];

task automatic compare_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
   if (actual !== expected) begin
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "stopped at the first error");
   end
endtask

// bit b of the key lands in index bit b mod index_w
function automatic flow_pkg::index_t fold_key(input flow_pkg::match_t key);
   flow_pkg::index_t acc;
   acc = '0;
   for (int b = 0; b < flow_pkg::match_w; b++) begin
      acc[b % flow_pkg::index_w] = acc[b % flow_pkg::index_w] ^ key[b];
   end
   return acc;
endfunction

function automatic flow_pkg::match_t rotl_key(input flow_pkg::match_t key);
   return (key << flow_pkg::hash_rot) | (key >> (flow_pkg::match_w - flow_pkg::hash_rot));
endfunction

// expected action of one lookup, counters follow
function automatic flow_pkg::action_t expect_lookup(input int p, input flow_pkg::match_t key);
   flow_pkg::index_t i0;
   flow_pkg::index_t i1;
   i0 = fold_key(key);
   i1 = fold_key(rotl_key(key));
   if (written[i0] && shadow[i0].match == key) begin
      exp_hit++;
      return shadow[i0].action;
   end
   if (written[i1] && shadow[i1].match == key) begin
      exp_hit++;
      return shadow[i1].action;
   end
   exp_miss++;
   exp_drop[p]++;
   return '0;
endfunction

function automatic flow_pkg::match_t rand_key();
   return {$urandom, $urandom, $urandom, $urandom};
endfunction

// never zero, so a hit is told apart from a drop
function automatic flow_pkg::action_t rand_action();
   return {$urandom, $urandom} | 64'd1;
endfunction

// ------------------------------
// handshake helpers
// ------------------------------
// id 0..3 are lookup ports, host_id is the host
task automatic wait_ack(input int id);
   logic [port_pkg::num_req-1:0] acks;
   do begin
      @(negedge asclk);
      acks = {host_ack, port_ack};
   end while (!acks[id]);
endtask

// done low for two cycles after ack, high on the third
task automatic expect_done(input int id);
   logic [port_pkg::num_req-1:0] dones;
   for (int c = 1; c <= 3; c++) begin
      @(negedge asclk);
      dones = {host_done, port_done};
      compare_value($sformatf("done[%0d] at cycle %0d after ack", id, c),
                    128'(c == 3), 128'(dones[id]));
   end
endtask

task automatic run_lookup(input int p, input flow_pkg::match_t key);
   flow_pkg::action_t exp_act;
   @(posedge asclk);
   #2;
   port_req[p]   = 1'b1;
   port_match[p] = key;
   wait_ack(p);
   exp_act = expect_lookup(p, key);
   @(posedge asclk);
   #2;
   port_req[p] = 1'b0;
   expect_done(p);
   compare_value($sformatf("action_out port %0d", p), 128'(exp_act), 128'(action_out));
endtask

// write data stays on the inputs until done
task automatic host_access(input logic wr, input flow_pkg::index_t addr,
                           input flow_pkg::entry_t ent);
   flow_pkg::entry_t exp_ent;
   @(posedge asclk);
   #2;
   host_req       = 1'b1;
   host_wr        = wr;
   host_addr      = addr;
   host_match_in  = ent.match;
   host_action_in = ent.action;
   wait_ack(port_pkg::host_id);
   if (wr) begin
      shadow[addr]  = ent;
      written[addr] = 1'b1;
      wr_addrs.push_back(addr);
   end
   exp_ent = shadow[addr];
   @(posedge asclk);
   #2;
   host_req = 1'b0;
   expect_done(port_pkg::host_id);
   compare_value("host_match_out", exp_ent.match, host_match_out);
   compare_value("host_action_out", 128'(exp_ent.action), 128'(host_action_out));
endtask

task automatic place_key(input flow_pkg::match_t key, input bit use_h1);
   flow_pkg::entry_t ent;
   ent.match  = key;
   ent.action = rand_action();
   host_access(1'b1, use_h1 ? fold_key(rotl_key(key)) : fold_key(key), ent);
endtask

task automatic check_counters();
   @(negedge asclk);
   compare_value("exact_hit", 128'(exp_hit), 128'(exact_hit));
   compare_value("exact_miss", 128'(exp_miss), 128'(exact_miss));
   for (int p = 0; p < port_pkg::num_ports; p++) begin
      compare_value($sformatf("drop_count[%0d]", p), 128'(exp_drop[p]), 128'(drop_count[p]));
   end
endtask

// ==== sim/tb_flow_tbl_ctrl.sv ====
`timescale 1ns/1ps

module tb_flow_tbl_ctrl;

   localparam int clk_period   = 40;
   localparam int num_tests    = 6;
   localparam int limit_cycles = num_tests * 200 + 10;

   logic                           asclk;
   logic                           aresetn;
   logic [port_pkg::num_ports-1:0] port_req;
   flow_pkg::match_t               port_match [port_pkg::num_ports];
   logic [port_pkg::num_ports-1:0] port_ack;
   logic [port_pkg::num_ports-1:0] port_done;
   flow_pkg::action_t              action_out;
   logic                           host_req;
   logic                           host_wr;
   flow_pkg::index_t               host_addr;
   flow_pkg::match_t               host_match_in;
   flow_pkg::action_t              host_action_in;
   logic                           host_ack;
   logic                           host_done;
   flow_pkg::match_t               host_match_out;
   flow_pkg::action_t              host_action_out;
   port_pkg::count_t               exact_hit;
   port_pkg::count_t               exact_miss;
   port_pkg::count_t               drop_count [port_pkg::num_ports];
   int                             cycle;

   flow_tbl_ctrl u_dut (
      .asclk           (asclk),
      .aresetn         (aresetn),
      .port_req        (port_req),
      .port_match      (port_match),
      .port_ack        (port_ack),
      .port_done       (port_done),
      .action_out      (action_out),
      .host_req        (host_req),
      .host_wr         (host_wr),
      .host_addr       (host_addr),
      .host_match_in   (host_match_in),
      .host_action_in  (host_action_in),
      .host_ack        (host_ack),
      .host_done       (host_done),
      .host_match_out  (host_match_out),
      .host_action_out (host_action_out),
      .exact_hit       (exact_hit),
      .exact_miss      (exact_miss),
      .drop_count      (drop_count)
   );

   `include "tb_tasks.svh"

   initial begin
      asclk = 1'b0;
      forever #(clk_period / 2) asclk = ~asclk;
   end

   always @(posedge asclk) begin
      cycle <= cycle + 1;
   end

   // at most one grant per cycle, in every test
   always @(negedge asclk) begin
      if (aresetn) begin
         compare_value("ack_onehot", 128'(1'b1), 128'($onehot0({host_ack, port_ack})));
      end
   end

   initial begin
      #(limit_cycles * clk_period);
      $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
      $display("Testbench failed");
      $fatal(1, "watchdog expired");
   end

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic check_reset_state();
      @(negedge asclk);
      compare_value("port_ack", '0, 128'(port_ack));
      compare_value("host_ack", '0, 128'(host_ack));
      compare_value("port_done", '0, 128'(port_done));
      compare_value("host_done", '0, 128'(host_done));
      compare_value("action_out", '0, 128'(action_out));
      check_counters();
   endtask

   task automatic write_read_entries();
      flow_pkg::entry_t ent;
      flow_pkg::index_t addrs [8];
      for (int i = 0; i < 8; i++) begin
         addrs[i]   = flow_pkg::index_t'($urandom);
         ent.match  = rand_key();
         ent.action = rand_action();
         host_access(1'b1, addrs[i], ent);
      end
      for (int i = 0; i < 8; i++) begin
         host_access(1'b0, addrs[i], '0);
      end
   endtask

   task automatic lookup_hits();
      flow_pkg::match_t key;
      for (int p = 0; p < port_pkg::num_ports; p++) begin
         for (int k = 0; k < 2; k++) begin
            key = rand_key();
            place_key(key, k == 1);
            run_lookup(p, key);
         end
      end
      check_counters();
   endtask

   task automatic lookup_misses();
      for (int p = 0; p < port_pkg::num_ports; p++) begin
         run_lookup(p, rand_key());
         run_lookup(p, rand_key());
      end
      check_counters();
   endtask

   // one key per round stays unwritten and misses
   task automatic contend_all();
      flow_pkg::match_t keys [port_pkg::num_ports];
      flow_pkg::index_t raddr;
      for (int r = 0; r < 4; r++) begin
         for (int p = 0; p < port_pkg::num_ports; p++) begin
            keys[p] = rand_key();
            if (p != r) begin
               place_key(keys[p], p % 2 == 1);
            end
         end
         raddr = wr_addrs[$urandom % wr_addrs.size()];
         fork
            run_lookup(0, keys[0]);
            run_lookup(1, keys[1]);
            run_lookup(2, keys[2]);
            run_lookup(3, keys[3]);
            host_access(1'b0, raddr, '0);
         join
      end
      check_counters();
   endtask

   task automatic issue_stream(input int p, input flow_pkg::match_t keys [8]);
      @(posedge asclk);
      #2;
      port_req[p]   = 1'b1;
      port_match[p] = keys[0];
      for (int i = 0; i < 8; i++) begin
         wait_ack(p);
         stream_act.push_back(expect_lookup(p, keys[i]));
         stream_cyc.push_back(cycle);
         @(posedge asclk);
         #2;
         if (i < 7) begin
            port_match[p] = keys[i + 1];
         end else begin
            port_req[p] = 1'b0;
         end
      end
   endtask

   task automatic collect_stream(input int p, input int n);
      for (int i = 0; i < n; i++) begin
         do begin
            @(negedge asclk);
         end while (!port_done[p]);
         compare_value("stream done cycle", 128'(stream_cyc.pop_front() + 3), 128'(cycle));
         compare_value("stream action_out", 128'(stream_act.pop_front()), 128'(action_out));
      end
   endtask

   task automatic back_to_back();
      flow_pkg::match_t keys [8];
      flow_pkg::entry_t ent;
      for (int i = 0; i < 8; i++) begin
         keys[i] = rand_key();
         if (i % 2 == 0) begin
            place_key(keys[i], i % 4 == 2);
         end
      end
      fork
         issue_stream(1, keys);
         collect_stream(1, 8);
      join
      // new action on probe 0, lookup granted right behind the write
      ent.match  = keys[0];
      ent.action = rand_action();
      fork
         host_access(1'b1, fold_key(keys[0]), ent);
         begin
            wait_ack(port_pkg::host_id);
            run_lookup(2, keys[0]);
         end
      join
      check_counters();
   endtask

   // ------------------------------
   // run
   // ------------------------------
   initial begin
      void'($urandom(32'hcd03));
      aresetn        = 1'b0;
      port_req       = '0;
      host_req       = 1'b0;
      host_wr        = 1'b0;
      host_addr      = '0;
      host_match_in  = '0;
      host_action_in = '0;
      for (int p = 0; p < port_pkg::num_ports; p++) begin
         port_match[p] = '0;
      end
      repeat (10) @(posedge asclk);
      #2;
      aresetn = 1'b1;
      check_reset_state();
      write_read_entries();
      lookup_hits();
      lookup_misses();
      contend_all();
      back_to_back();
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+sim
src/flow_pkg.sv
src/port_pkg.sv
src/lookup_arbiter.sv
src/flow_hash.sv
src/exact_table.sv
src/action_select.sv
src/flow_tbl_ctrl.sv
sim/tb_flow_tbl_ctrl.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_flow_tbl_ctrl -o tb_flow_tbl_ctrl
	./obj_dir/tb_flow_tbl_ctrl

clean:
	rm -rf obj_dir

.PHONY: sim clean
